// ==== verilog.f ====
+incdir+include
hdl/comp_regif_pkg.sv
hdl/wb_reg_port.sv
hdl/conv_fc_regs.sv
hdl/lpe_regs.sv
hdl/comp_regif.sv
tests/comp_regif_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the compute register interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vcomp_regif_tb

verilator --binary --timing -j 0 --top-module comp_regif_tb --Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== tests/comp_regif_patterns.txt ====
// opcode  address/selector  data  expected, all hex
// 1 write, 2 read and compare, 3 staged group compare, 4 COMP_CTRL go write, f end
// reset values
2 00 00000000 00000000
2 04 00000000 00000000
2 08 00000000 00000000
2 0c 00000000 00000000
2 10 00000000 00000000
2 14 00000000 00000000
2 18 00000000 00000000
2 20 00000000 00000000
2 24 00000000 00000000
2 28 00000000 00000000
2 2c 00000000 00000000
2 30 00000000 00000000
3 0 00000000 00000000
3 1 00000000 00000000
3 2 00000000 00000000
3 3 00000000 00000000
3 4 00000000 00000000
3 5 00000000 00000000
3 6 00000000 00000000
3 8 00000000 00000000
3 a 00000000 00000000
3 b 00000000 00000000
3 c 00000000 00000000
// all ones, only defined field bits read back
1 00 ffffffff 00000000
2 00 00000000 3f3f3f3f
1 04 ffffffff 00000000
2 04 00000000 07ff000f
1 08 ffffffff 00000000
2 08 00000000 3f3f3f3f
1 0c ffffffff 00000000
2 0c 00000000 00003f3f
1 10 ffffffff 00000000
2 10 00000000 0f0f0f0f
1 14 ffffffff 00000000
2 14 00000000 07ff07ff
1 1c ffffffff 00000000
2 1c 00000000 00000000
1 20 ffffffff 00000000
2 20 00000000 1fff1fff
1 24 ffffffff 00000000
2 24 00000000 1fff1fff
1 28 ffffffff 00000000
2 28 00000000 1fff1fff
1 2c ffffffff 00000000
2 2c 00000000 1fff1fff
1 30 ffffffff 00000000
2 30 00000000 77f00000
1 34 ffffffff 00000000
2 34 00000000 00000000
// nothing staged before a go
3 0 00000000 00000000
3 1 00000000 00000000
// fc go stages fc only, LPE staged with merge, image and bypass
4 18 40000000 00000001
2 18 00000000 00000000
3 5 00000000 07ff07ff
3 0 00000000 00000000
3 2 00000000 00000000
3 6 00000000 1fff1fff
3 8 00000000 1fff1fff
3 a 00000000 7f010100
3 b 00000000 00000003
// both go bits, conv staged and fc kept
1 00 2a152b01 00000000
1 04 0555000a 00000000
1 08 10203f04 00000000
1 0c 00000203 00000000
1 10 01020304 00000000
1 14 01230456 00000000
3 0 00000000 00000000
4 18 c0000000 00000011
3 0 00000000 2a152b01
3 1 00000000 0555000a
3 2 00000000 10203f04
3 3 00000000 01020304
3 4 00000000 00020003
3 5 00000000 07ff07ff
// merge clear, dest from the dest registers
1 20 0abc0123 00000000
1 24 00050040 00000000
1 28 00221000 00000000
1 2c 00030007 00000000
1 30 41510000 00000000
2 30 00000000 41510000
4 18 80000000 00000010
3 6 00000000 0abc0123
3 7 00000000 00050040
3 8 00000000 00221000
3 9 00000000 00030007
3 a 00000000 15010001
3 b 00000000 00000001
// sprmps 3 keeps mode all, merge set copies src into dest
1 30 37e30000 00000000
2 30 00000000 37e10000
4 18 40000000 00000001
3 5 00000000 01230456
3 8 00000000 0abc0123
3 9 00000000 00050040
3 a 00000000 7e000101
3 b 00000000 00000000
3 0 00000000 2a152b01
// no go bit, no start pulse
4 18 00000000 00000000
3 c 00000000 00000000
// wait table for none and image
1 30 00020000 00000000
4 18 80000000 00000010
3 a 00000000 00000002
3 b 00000000 0000001f
3 8 00000000 00221000
1 30 10020000 00000000
4 18 40000000 00000001
3 b 00000000 0000000f
1 30 00000000 00000000
4 18 c0000000 00000011
3 b 00000000 00000007
f 00 00000000 00000000

// ==== include/tb_bus_tasks.svh ====
// Wishbone classic master tasks and the value compare of the testbench
// expects clk, the wb_* signals, errors, checks, ACK_LIMIT and DRIVE_DELAY
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("Mismatch %s got 0x%08h expected 0x%08h", name, got, expected);
    end
endtask

// start an access and wait for ack, which must come one cycle later
task automatic bus_start(input logic we, input logic [5:0] adr, input word_t data,
                         output word_t rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = 4'hf;
    waited   = 0;
    do begin
        @(posedge clk);
        #1;
        waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (wb_ack) begin
        check_value("wb_ack latency", waited, 32'd1);
    end else begin
        errors++;
        $display("no ack within %0d cycles for address 0x%02h", ACK_LIMIT, adr);
    end
    // read data is valid while ack is high
    rdata = wb_dat_r;
endtask

// drop the strobe in the cycle after ack, ack must be gone by then
task automatic bus_end();
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_sel = 4'h0;
    check_value("wb_ack", 32'(wb_ack), 32'd0);
endtask

task automatic wb_write(input logic [5:0] adr, input word_t data);
    word_t rd_unused;
    bus_start(1'b1, adr, data, rd_unused);
    bus_end();
endtask

task automatic wb_read(input logic [5:0] adr, output word_t data);
    bus_start(1'b0, adr, '0, data);
    bus_end();
endtask

`endif

// ==== tests/comp_regif_tb.sv ====
// testbench for the compute register interface
// replays Wishbone accesses, go writes and staged field checks from a pattern file
`timescale 1ns/1ps
`default_nettype none

module comp_regif_tb
    import comp_regif_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int ACK_LIMIT    = 8;
    localparam int MAX_OPS      = 128;

    // pattern opcodes
    localparam logic [31:0] OP_WRITE  = 32'h1;
    localparam logic [31:0] OP_READ   = 32'h2;
    localparam logic [31:0] OP_STAGED = 32'h3;
    localparam logic [31:0] OP_GO     = 32'h4;
    localparam logic [31:0] OP_END    = 32'hf;
    // status is the last staged selector
    localparam logic [31:0] SEL_STATUS = 32'hc;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [5:0] wb_adr;
    word_t      wb_dat_w;
    logic [3:0] wb_sel;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       go_comp_conv;
    logic       go_comp_fc;
    conv_cfg_t  conv_cfg;
    fc_cfg_t    fc_cfg;
    logic       start_lpe;
    lpe_cfg_t   lpe_cfg;
    wait_t      wait_lpe;

    // four words per operation: opcode, address or selector, data, expected
    word_t pat_mem [0:4*MAX_OPS-1];
    int    num_ops;
    int    errors;
    int    checks;
    bit    loaded = 1'b0;

    comp_regif dut (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .go_comp_conv (go_comp_conv),
        .go_comp_fc   (go_comp_fc),
        .conv_cfg     (conv_cfg),
        .fc_cfg       (fc_cfg),
        .start_lpe    (start_lpe),
        .lpe_cfg      (lpe_cfg),
        .wait_lpe     (wait_lpe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    `include "tb_bus_tasks.svh"

    // =========================================================================
    // staged field groups, each field zero-extended to a byte or half word
    // =========================================================================
    function automatic word_t staged_word(input logic [31:0] sel);
        case (sel)
            32'h0: return {8'(conv_cfg.k_hori_delta), 8'(conv_cfg.k_vert_delta),
                           8'(conv_cfg.k_hori_len), 8'(conv_cfg.k_vert_len)};
            32'h1: return {16'(conv_cfg.k_size_len), 16'(conv_cfg.slice_max)};
            32'h2: return {8'(conv_cfg.if_hori_len), 8'(conv_cfg.if_vert_len),
                           8'(conv_cfg.of_hori_len), 8'(conv_cfg.of_vert_len)};
            32'h3: return {8'(conv_cfg.pad_up), 8'(conv_cfg.pad_down),
                           8'(conv_cfg.pad_left), 8'(conv_cfg.pad_right)};
            32'h4: return {16'(conv_cfg.hori_stride), 16'(conv_cfg.vert_stride)};
            32'h5: return {16'(fc_cfg.len), 16'(fc_cfg.addr)};
            32'h6: return {16'(lpe_cfg.src.len), 16'(lpe_cfg.src.addr)};
            32'h7: return {16'(lpe_cfg.src.iter), 16'(lpe_cfg.src.skip)};
            32'h8: return {16'(lpe_cfg.dest.len), 16'(lpe_cfg.dest.addr)};
            32'h9: return {16'(lpe_cfg.dest.iter), 16'(lpe_cfg.dest.skip)};
            32'ha: return {8'(lpe_cfg.overlay), 8'(lpe_cfg.relu),
                           8'(lpe_cfg.acc_bypass), 8'(lpe_cfg.sprmps)};
            32'hb: return 32'(wait_lpe);
            32'hc: return {23'd0, start_lpe, 3'd0, go_comp_conv, 3'd0, go_comp_fc};
            default: return '0;
        endcase
    endfunction

    function automatic string staged_name(input logic [31:0] sel);
        case (sel)
            32'h0: return "conv_cfg kernel";
            32'h1: return "conv_cfg k_size_len/slice_max";
            32'h2: return "conv_cfg feature map";
            32'h3: return "conv_cfg pad";
            32'h4: return "conv_cfg stride";
            32'h5: return "fc_cfg len/addr";
            32'h6: return "lpe_cfg.src len/addr";
            32'h7: return "lpe_cfg.src iter/skip";
            32'h8: return "lpe_cfg.dest len/addr";
            32'h9: return "lpe_cfg.dest iter/skip";
            32'ha: return "lpe_cfg mode";
            32'hb: return "wait_lpe";
            default: return "start_lpe/go_comp_conv/go_comp_fc";
        endcase
    endfunction

    // =========================================================================
    // pattern player
    // =========================================================================
    // COMP_CTRL write, go outputs in the ack cycle, then the start pulse
    task automatic go_write(input logic [5:0] adr, input word_t data,
                            input word_t exp_status);
        word_t rd_unused;
        logic  any_go;
        any_go = data[GO_CONV_BIT] | data[GO_FC_BIT];
        bus_start(1'b1, adr, data, rd_unused);
        check_value(staged_name(SEL_STATUS), staged_word(SEL_STATUS), exp_status);
        bus_end();
        check_value("start_lpe", 32'(start_lpe), 32'(any_go));
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("start_lpe", 32'(start_lpe), 32'd0);
    endtask

    task automatic play_op(input int n);
        word_t op;
        word_t arg;
        word_t data;
        word_t expected;
        word_t got;
        op       = pat_mem[4*n];
        arg      = pat_mem[4*n+1];
        data     = pat_mem[4*n+2];
        expected = pat_mem[4*n+3];
        case (op)
            OP_WRITE: wb_write(arg[5:0], data);
            OP_READ: begin
                wb_read(arg[5:0], got);
                check_value($sformatf("wb_dat_r at 0x%02h", arg[5:0]), got, expected);
            end
            OP_STAGED: begin
                if (arg > SEL_STATUS) begin
                    errors++;
                    $display("pattern %0d uses an unknown selector 0x%0h", n, arg);
                end else begin
                    check_value(staged_name(arg), staged_word(arg), expected);
                end
            end
            OP_GO: go_write(arg[5:0], data, expected);
            default: begin
                errors++;
                $display("pattern %0d has an unknown opcode 0x%0h", n, op);
            end
        endcase
    endtask

    function automatic int count_ops();
        int i;
        for (i = 0; i < MAX_OPS; i++) begin
            if (pat_mem[4*i] === OP_END) begin
                return i;
            end
        end
        return -1;
    endfunction

    initial begin : main
        int n;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        errors   = 0;
        checks   = 0;
        $readmemh("tests/comp_regif_patterns.txt", pat_mem);
        num_ops = count_ops();
        if (num_ops < 0) begin
            errors++;
            $display("pattern file is missing or has no end marker");
            num_ops = 0;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (n = 0; n < num_ops; n++) begin
            play_op(n);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ten cycles per operation plus margin for reset
    initial begin : watchdog
        wait (loaded);
        repeat (num_ops * 10 + 100) @(posedge clk);
        $display("timeout, the pattern run did not finish within %0d cycles",
                 num_ops * 10 + 100);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/comp_regif.sv ====
// compute register interface top level
// Wishbone port in front of the conv/FC bank and the LPE bank
`timescale 1ns/1ps
`default_nettype none

module comp_regif
    import comp_regif_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    // Wishbone classic slave
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire logic       wb_we,
    input  wire logic [5:0] wb_adr,
    input  wire word_t      wb_dat_w,
    input  wire logic [3:0] wb_sel,
    output word_t           wb_dat_r,
    output logic            wb_ack,

    // compute engine side
    output logic            go_comp_conv,
    output logic            go_comp_fc,
    output conv_cfg_t       conv_cfg,
    output fc_cfg_t         fc_cfg,
    output logic            start_lpe,
    output lpe_cfg_t        lpe_cfg,
    output wait_t           wait_lpe
);

    reg_wr_t conv_wr;
    reg_wr_t lpe_wr;
    word_t   conv_rdata;
    word_t   lpe_rdata;
    go_t     go;

    assign go_comp_conv = go.conv;
    assign go_comp_fc   = go.fc;

    wb_reg_port u_port (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .conv_rdata (conv_rdata),
        .lpe_rdata  (lpe_rdata),
        .conv_wr    (conv_wr),
        .lpe_wr     (lpe_wr)
    );

    conv_fc_regs u_conv_fc (
        .clk      (clk),
        .rst      (rst),
        .wr       (conv_wr),
        .rdata    (conv_rdata),
        .go       (go),
        .conv_cfg (conv_cfg),
        .fc_cfg   (fc_cfg)
    );

    lpe_regs u_lpe (
        .clk       (clk),
        .rst       (rst),
        .wr        (lpe_wr),
        .go        (go),
        .rdata     (lpe_rdata),
        .start_lpe (start_lpe),
        .lpe_cfg   (lpe_cfg),
        .wait_lpe  (wait_lpe)
    );

endmodule

`default_nettype wire

// ==== hdl/lpe_regs.sv ====
// local processing engine configuration bank
// holds the LPE source, destination and mode registers, stages them on
// any go, pulses start_lpe and looks up the LPE wait count
`timescale 1ns/1ps
`default_nettype none

module lpe_regs
    import comp_regif_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire reg_wr_t wr,
    input  wire go_t     go,
    output word_t        rdata,
    output logic         start_lpe,
    output lpe_cfg_t     lpe_cfg,
    output wait_t        wait_lpe
);

    lpe_xfer_t src_reg;
    lpe_xfer_t dest_reg;

    // MODE fields
    logic      mode_relu;
    logic      mode_addr_merge;
    logic      mode_acc_bypass;
    overlay_t  mode_overlay;
    sprmps_e   mode_sprmps;

    logic      any_go;

    // two 13-bit fields at 28:16 and 12:0
    function automatic word_t pack_pair(input lpe_addr_t hi, input lpe_addr_t lo);
        return {3'd0, hi, 3'd0, lo};
    endfunction

    function automatic wait_t wait_count(input sprmps_e mode, input logic bypass);
        wait_t cnt;
        case (mode)
            SPRMPS_IMAGE: cnt = bypass ? WAIT_IMAGE_BYP : WAIT_IMAGE;
            SPRMPS_ALL:   cnt = bypass ? WAIT_ALL_BYP : WAIT_ALL;
            default:      cnt = bypass ? WAIT_NONE_BYP : WAIT_NONE;
        endcase
        return cnt;
    endfunction

    // =========================================================================
    // configuration registers
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_reg         <= '0;
            dest_reg        <= '0;
            mode_relu       <= 1'b0;
            mode_addr_merge <= 1'b0;
            mode_acc_bypass <= 1'b0;
            mode_overlay    <= '0;
            mode_sprmps     <= SPRMPS_IMAGE;
        end else if (wr.valid) begin
            case (wr.idx)
                IDX_LPE_SRC0[2:0]: begin
                    src_reg.len  <= wr.data[28:16];
                    src_reg.addr <= wr.data[12:0];
                end
                IDX_LPE_SRC1[2:0]: begin
                    src_reg.iter <= wr.data[28:16];
                    src_reg.skip <= wr.data[12:0];
                end
                IDX_LPE_DEST0[2:0]: begin
                    dest_reg.len  <= wr.data[28:16];
                    dest_reg.addr <= wr.data[12:0];
                end
                IDX_LPE_DEST1[2:0]: begin
                    dest_reg.iter <= wr.data[28:16];
                    dest_reg.skip <= wr.data[12:0];
                end
                IDX_LPE_MODE[2:0]: begin
                    mode_relu       <= wr.data[30];
                    mode_addr_merge <= wr.data[29];
                    mode_acc_bypass <= wr.data[28];
                    mode_overlay    <= wr.data[26:20];
                    // 3 is not a mode, keep the old one
                    if (wr.data[17:16] != 2'd3) begin
                        mode_sprmps <= sprmps_e'(wr.data[17:16]);
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (wr.idx)
            IDX_LPE_SRC0[2:0]:  rdata = pack_pair(src_reg.len, src_reg.addr);
            IDX_LPE_SRC1[2:0]:  rdata = pack_pair(src_reg.iter, src_reg.skip);
            IDX_LPE_DEST0[2:0]: rdata = pack_pair(dest_reg.len, dest_reg.addr);
            IDX_LPE_DEST1[2:0]: rdata = pack_pair(dest_reg.iter, dest_reg.skip);
            IDX_LPE_MODE[2:0]:
                rdata = {1'b0, mode_relu, mode_addr_merge, mode_acc_bypass,
                         1'b0, mode_overlay, 2'd0, mode_sprmps, 16'd0};
            default:            rdata = '0;
        endcase
    end

    // =========================================================================
    // staging and start pulse
    // =========================================================================
    // every compute go also kicks the LPE
    assign any_go = go.conv | go.fc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_lpe <= 1'b0;
            lpe_cfg   <= '{sprmps: SPRMPS_IMAGE, default: '0};
            wait_lpe  <= '0;
        end else begin
            start_lpe <= any_go;
            if (any_go) begin
                lpe_cfg.src        <= src_reg;
                // address merge writes results back over the source
                lpe_cfg.dest       <= mode_addr_merge ? src_reg : dest_reg;
                lpe_cfg.overlay    <= mode_overlay;
                lpe_cfg.relu       <= mode_relu;
                lpe_cfg.acc_bypass <= mode_acc_bypass;
                lpe_cfg.sprmps     <= mode_sprmps;
                wait_lpe           <= wait_count(mode_sprmps, mode_acc_bypass);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_fc_regs.sv ====
// convolution and fully-connected configuration bank
// holds the conv and FC registers, decodes the go bits of COMP_CTRL and
// stages the conv or FC configuration for the compute engines
`timescale 1ns/1ps
`default_nettype none

module conv_fc_regs
    import comp_regif_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire reg_wr_t wr,
    output word_t        rdata,
    output go_t          go,
    output conv_cfg_t    conv_cfg,
    output fc_cfg_t      fc_cfg
);

    // live register contents, same layout as the staged copies
    conv_cfg_t conv_reg;
    fc_cfg_t   fc_reg;
    logic      ctrl_wr;

    // four 6-bit fields on byte boundaries, top two bits of each byte zero
    function automatic word_t pack_dims(input dim_t f3, input dim_t f2,
                                        input dim_t f1, input dim_t f0);
        return {2'd0, f3, 2'd0, f2, 2'd0, f1, 2'd0, f0};
    endfunction

    // =========================================================================
    // configuration registers
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            conv_reg <= '0;
            fc_reg   <= '0;
        end else if (wr.valid) begin
            case (wr.idx)
                IDX_CONV_K_SIZE0[2:0]: begin
                    conv_reg.k_hori_delta <= wr.data[29:24];
                    conv_reg.k_vert_delta <= wr.data[21:16];
                    conv_reg.k_hori_len   <= wr.data[13:8];
                    conv_reg.k_vert_len   <= wr.data[5:0];
                end
                IDX_CONV_K_SIZE1[2:0]: begin
                    conv_reg.k_size_len <= wr.data[26:16];
                    conv_reg.slice_max  <= wr.data[3:0];
                end
                IDX_CONV_FMAP[2:0]: begin
                    conv_reg.if_hori_len <= wr.data[29:24];
                    conv_reg.if_vert_len <= wr.data[21:16];
                    conv_reg.of_hori_len <= wr.data[13:8];
                    conv_reg.of_vert_len <= wr.data[5:0];
                end
                IDX_CONV_STRIDE[2:0]: begin
                    conv_reg.hori_stride <= wr.data[13:8];
                    conv_reg.vert_stride <= wr.data[5:0];
                end
                IDX_CONV_PAD_SIZE[2:0]: begin
                    conv_reg.pad_up    <= wr.data[27:24];
                    conv_reg.pad_down  <= wr.data[19:16];
                    conv_reg.pad_left  <= wr.data[11:8];
                    conv_reg.pad_right <= wr.data[3:0];
                end
                IDX_FC_SRC[2:0]: begin
                    fc_reg.len  <= wr.data[26:16];
                    fc_reg.addr <= wr.data[10:0];
                end
                default: ;
            endcase
        end
    end

    // readback, COMP_CTRL and the unmapped slot read zero
    always_comb begin
        case (wr.idx)
            IDX_CONV_K_SIZE0[2:0]:
                rdata = pack_dims(conv_reg.k_hori_delta, conv_reg.k_vert_delta,
                                  conv_reg.k_hori_len, conv_reg.k_vert_len);
            IDX_CONV_K_SIZE1[2:0]:
                rdata = {5'd0, conv_reg.k_size_len, 12'd0, conv_reg.slice_max};
            IDX_CONV_FMAP[2:0]:
                rdata = pack_dims(conv_reg.if_hori_len, conv_reg.if_vert_len,
                                  conv_reg.of_hori_len, conv_reg.of_vert_len);
            IDX_CONV_STRIDE[2:0]:
                rdata = pack_dims('0, '0, conv_reg.hori_stride, conv_reg.vert_stride);
            IDX_CONV_PAD_SIZE[2:0]:
                rdata = {4'd0, conv_reg.pad_up, 4'd0, conv_reg.pad_down,
                         4'd0, conv_reg.pad_left, 4'd0, conv_reg.pad_right};
            IDX_FC_SRC[2:0]:
                rdata = {5'd0, fc_reg.len, 5'd0, fc_reg.addr};
            default:
                rdata = '0;
        endcase
    end

    // =========================================================================
    // go decode and staging
    // =========================================================================
    assign ctrl_wr = wr.valid && (wr.idx == IDX_COMP_CTRL[2:0]);
    assign go.conv = ctrl_wr & wr.data[GO_CONV_BIT];
    assign go.fc   = ctrl_wr & wr.data[GO_FC_BIT];

    // conv wins when both go bits are set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            conv_cfg <= '0;
            fc_cfg   <= '0;
        end else if (go.conv) begin
            conv_cfg <= conv_reg;
        end else if (go.fc) begin
            fc_cfg <= fc_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_reg_port.sv ====
// Wishbone classic slave for the compute register file
// one-cycle ack, bank select on index bit 3, write routing to the
// addressed bank and registered readback of the selected bank word
`timescale 1ns/1ps
`default_nettype none

module wb_reg_port
    import comp_regif_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    // Wishbone classic slave side
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire logic       wb_we,
    input  wire logic [5:0] wb_adr,
    input  wire word_t      wb_dat_w,
    // byte lanes ignored, every register is a full word
    input  wire logic [3:0] wb_sel,
    output word_t           wb_dat_r,
    output logic            wb_ack,

    // bank side
    input  wire word_t      conv_rdata,
    input  wire word_t      lpe_rdata,
    output reg_wr_t         conv_wr,
    output reg_wr_t         lpe_wr
);

    reg_idx_t idx;
    logic     bank_lpe;
    logic     access;
    logic     wr_cycle;
    logic     rd_start;

    // word index, drop the byte offset
    assign idx      = wb_adr[5:2];
    assign bank_lpe = idx[3];

    assign access   = wb_cyc & wb_stb;
    // write lands at the edge that closes the ack cycle
    assign wr_cycle = access & wb_ack & wb_we;
    // read word captured on the edge that raises ack
    assign rd_start = access & ~wb_ack & ~wb_we;

    // =========================================================================
    // handshake
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access & ~wb_ack;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_dat_r <= '0;
        end else if (rd_start) begin
            wb_dat_r <= bank_lpe ? lpe_rdata : conv_rdata;
        end
    end

    // =========================================================================
    // write routing
    // =========================================================================
    always_comb begin
        conv_wr.valid = wr_cycle & ~bank_lpe;
        conv_wr.idx   = idx[2:0];
        conv_wr.data  = wb_dat_w;

        lpe_wr.valid  = wr_cycle & bank_lpe;
        lpe_wr.idx    = idx[2:0];
        lpe_wr.data   = wb_dat_w;
    end

endmodule

`default_nettype wire

// ==== hdl/comp_regif_pkg.sv ====
// compute register interface package
// register map, field widths, go bit positions, LPE wait table and the
// structs that carry writes and staged configuration between blocks
`default_nettype none

package comp_regif_pkg;

    // =========================================================================
    // bus word and register map
    // =========================================================================
    typedef logic [31:0] word_t;
    // word index from address bits 5:2, bit 3 picks the LPE bank
    typedef logic [3:0]  reg_idx_t;

    localparam reg_idx_t IDX_CONV_K_SIZE0  = 4'd0;
    localparam reg_idx_t IDX_CONV_K_SIZE1  = 4'd1;
    localparam reg_idx_t IDX_CONV_FMAP     = 4'd2;
    localparam reg_idx_t IDX_CONV_STRIDE   = 4'd3;
    localparam reg_idx_t IDX_CONV_PAD_SIZE = 4'd4;
    localparam reg_idx_t IDX_FC_SRC        = 4'd5;
    localparam reg_idx_t IDX_COMP_CTRL     = 4'd6;

    localparam reg_idx_t IDX_LPE_SRC0      = 4'd8;
    localparam reg_idx_t IDX_LPE_SRC1      = 4'd9;
    localparam reg_idx_t IDX_LPE_DEST0     = 4'd10;
    localparam reg_idx_t IDX_LPE_DEST1     = 4'd11;
    localparam reg_idx_t IDX_LPE_MODE      = 4'd12;

    // go bits in COMP_CTRL
    localparam int GO_CONV_BIT = 31;
    localparam int GO_FC_BIT   = 30;

    // =========================================================================
    // field widths
    // =========================================================================
    typedef logic [5:0]  dim_t;
    typedef logic [3:0]  pad_t;
    typedef logic [10:0] ksize_t;
    typedef logic [10:0] sram_addr_t;
    typedef logic [12:0] lpe_addr_t;
    typedef logic [6:0]  overlay_t;
    typedef logic [4:0]  wait_t;

    typedef enum logic [1:0] {
        SPRMPS_IMAGE = 2'd0,
        SPRMPS_ALL   = 2'd1,
        SPRMPS_NONE  = 2'd2
    } sprmps_e;

    // LPE wait count per suppression mode, plain and with accumulator bypass
    localparam wait_t WAIT_IMAGE     = 5'd7;
    localparam wait_t WAIT_IMAGE_BYP = 5'd3;
    localparam wait_t WAIT_ALL       = 5'd1;
    localparam wait_t WAIT_ALL_BYP   = 5'd0;
    localparam wait_t WAIT_NONE      = 5'd31;
    localparam wait_t WAIT_NONE_BYP  = 5'd15;

    // =========================================================================
    // structs
    // =========================================================================
    typedef struct packed {
        logic       valid;
        logic [2:0] idx;
        word_t      data;
    } reg_wr_t;

    typedef struct packed {
        logic conv;
        logic fc;
    } go_t;

    typedef struct packed {
        dim_t   k_hori_len;
        dim_t   k_vert_len;
        dim_t   k_hori_delta;
        dim_t   k_vert_delta;
        ksize_t k_size_len;
        pad_t   slice_max;
        dim_t   if_hori_len;
        dim_t   if_vert_len;
        dim_t   of_hori_len;
        dim_t   of_vert_len;
        dim_t   hori_stride;
        dim_t   vert_stride;
        pad_t   pad_up;
        pad_t   pad_down;
        pad_t   pad_left;
        pad_t   pad_right;
    } conv_cfg_t;

    typedef struct packed {
        sram_addr_t addr;
        sram_addr_t len;
    } fc_cfg_t;

    // one LPE transfer description, used for both source and destination
    typedef struct packed {
        lpe_addr_t addr;
        lpe_addr_t len;
        lpe_addr_t iter;
        lpe_addr_t skip;
    } lpe_xfer_t;

    typedef struct packed {
        lpe_xfer_t src;
        lpe_xfer_t dest;
        overlay_t  overlay;
        logic      relu;
        logic      acc_bypass;
        sprmps_e   sprmps;
    } lpe_cfg_t;

endpackage

`default_nettype wire
